//--- list.f
verilog/spi_frame_pkg.sv
verilog/reg_map_pkg.sv
verilog/spi_byte_shifter.sv
verilog/word_assembler.sv
verilog/spi_frame_control.sv
verilog/reg_bank.sv
verilog/apb_reg_port.sv
verilog/spi_reg_bridge.sv
bench/bridge_checker.sv
bench/tb_spi_reg_bridge.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
# The run counts as passed only if the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_spi_reg_bridge \
  && ./obj_dir/Vtb_spi_reg_bridge | tee /dev/stderr | grep -q "^>>> PASS$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- bench/bridge_patterns.txt
# kind addr data expect err, all fields hex
# sw sr sx su use a register index, aw ar use an APB byte address
# ov writes expect over APB while an SPI frame writes data to the same index
ar 00 0 0 0
ar 04 0 0 0
ar 08 0 0 0
ar 0c 0 0 0
ar 10 0 0 0
ar 14 0 0 0
ar 18 0 0 0
ar 1c 0 0 0
sr 05 0 0 0
sw 03 89abcdef 0 0
ar 0c 0 89abcdef 0
aw 1c 13572468 0 0
sr 07 0 13572468 0
aw 24 deadbeef 0 1
ar 24 0 0 1
aw 06 cafef00d 0 1
ar 06 0 0 1
ar 04 0 0 0
ar 1c 0 13572468 0
sx 02 11223344 0 0
su 02 55 0 0
ar 08 0 0 0
sr 02 0 0 0
sr 03 0 89abcdef 0
ov 04 aaaa5555 0f0f0f0f 0
ar 10 0 0f0f0f0f 0
sr 04 0 0f0f0f0f 0
sw 00 a5a5c3c3 0 0
sr 00 0 a5a5c3c3 0
ar 00 0 a5a5c3c3 0

//--- bench/tb_spi_reg_bridge.sv
// Runs from the project root to find its pattern file and uses a fixed SCK half period of 12 clk
`timescale 1ns/1ns
module tb_spi_reg_bridge;

  import reg_map_pkg::*;

  localparam int half_period = 12;
  localparam int apb_limit   = 16;
  localparam int frame_limit = 4000;

  logic                  clk;
  logic                  resetn;
  logic                  sck;
  logic                  cs;
  logic                  copi;
  logic                  cipo;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [apb_addr_w-1:0] paddr;
  logic [data_w-1:0]     pwdata;
  logic [data_w-1:0]     prdata;
  logic                  pready;
  logic                  pslverr;
  logic [data_w-1:0]     exp_data;
  logic                  exp_err;
  logic [1:0]            exp_wait;
  int                    value_errs;
  int                    reads_done;
  int                    tb_errs;
  int                    ops;
  int                    fd;
  int                    code;
  logic [7:0]            frame_bytes [6];
  logic                  last_rise;
  logic [8*160-1:0]      line;
  logic [15:0]           kind;
  logic [31:0]           f_addr;
  logic [31:0]           f_data;
  logic [31:0]           f_exp;
  logic [31:0]           f_err;

  spi_reg_bridge i_spi_reg_bridge (
    .clk(clk), .resetn(resetn), .sck(sck), .cs(cs), .copi(copi), .cipo(cipo),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  bridge_checker i_checker (
    .clk(clk), .resetn(resetn), .sck(sck), .cs(cs), .copi(copi), .cipo(cipo),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr), .exp_data(exp_data),
    .exp_err(exp_err), .exp_wait(exp_wait), .value_errs(value_errs),
    .reads_done(reads_done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Hard stop in case a frame or transfer never finishes
  initial begin
    #2000000;
    $display("simulation timed out before the pattern file was done");
    $display(">>> FAIL");
    $finish;
  end

  task automatic tick();
    @(posedge clk);
  endtask

  // Opcode, register index, then the word LSB first
  task automatic set_frame(input logic [7:0] op, input logic [7:0] idx,
                           input logic [31:0] word);
    frame_bytes[0] = op;
    frame_bytes[1] = idx;
    for (int i = 0; i < 4; i++) begin
      frame_bytes[i+2] = word[8*i +: 8];
    end
  endtask

  // Mode 0 with COPI changing while SCK is low and CS raised after count bytes
  task automatic spi_send(input int count);
    cs <= 1'b0;
    repeat (half_period) tick();
    for (int i = 0; i < count; i++) begin
      for (int b = 7; b >= 0; b--) begin
        sck  <= 1'b0;
        copi <= frame_bytes[i][b];
        repeat (half_period) tick();
        sck <= 1'b1;
        if (i == count - 1 && b == 0) begin
          last_rise <= 1'b1;
        end
        repeat (half_period) tick();
      end
    end
    sck  <= 1'b0;
    copi <= 1'b0;
    repeat (half_period) tick();
    cs <= 1'b1;
    repeat (2 * half_period) tick();
  endtask

  task automatic apb_xfer(input logic wr, input logic [7:0] a, input logic [31:0] d);
    int n;
    n = 0;
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= a;
    pwdata  <= d;
    tick();
    penable <= 1'b1;
    tick();
    while (!pready && n < apb_limit) begin
      tick();
      n++;
    end
    if (!pready) begin
      tb_errs++;
      $display("APB transfer to address %h never got pready", a);
    end
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // APB write timed so its access phase lands on the SPI commit cycle
  task automatic overlap_write();
    int n;
    n = 0;
    set_frame(8'h02, f_addr[7:0], f_data);
    last_rise <= 1'b0;
    fork
      spi_send(6);
      begin
        tick();
        while (!last_rise && n < frame_limit) begin
          tick();
          n++;
        end
        if (!last_rise) begin
          tb_errs++;
          $display("SPI frame never reached its last SCK rise");
        end
        // Setup 4 cycles after the last rise puts the access cycle on spi_we
        repeat (3) tick();
        apb_xfer(1'b1, {f_addr[5:0], 2'b00}, f_exp);
      end
    join
  endtask

  task automatic run_op();
    exp_data <= f_exp;
    exp_err  <= f_err[0];
    // Only a transfer that meets an SPI commit waits one cycle
    exp_wait <= (kind == "ov") ? 2'd1 : 2'd0;
    case (kind)
      "sw": begin
        set_frame(8'h02, f_addr[7:0], f_data);
        spi_send(6);
      end
      "sr": begin
        set_frame(8'h03, f_addr[7:0], 32'h0);
        spi_send(6);
      end
      "sx": begin
        set_frame(8'h02, f_addr[7:0], f_data);
        spi_send(4);
      end
      "su": begin
        set_frame(f_data[7:0], f_addr[7:0], {4{f_data[7:0]}});
        spi_send(6);
      end
      "aw": apb_xfer(1'b1, f_addr[7:0], f_data);
      "ar": apb_xfer(1'b0, f_addr[7:0], 32'h0);
      "ov": overlap_write();
      default: begin
        tb_errs++;
        $display("unknown operation kind in pattern file");
      end
    endcase
  endtask

  initial begin
    void'($urandom(32'hc22e));
    resetn    = 1'b1;
    sck       = 1'b0;
    cs        = 1'b1;
    copi      = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    exp_data  = '0;
    exp_err   = 1'b0;
    exp_wait  = 2'd0;
    last_rise = 1'b0;
    tb_errs   = 0;
    ops       = 0;
    repeat (16) tick();
    resetn <= 1'b0;
    repeat (4) tick();
    fd = $fopen("bench/bridge_patterns.txt", "r");
    if (fd == 0) begin
      tb_errs++;
      $display("could not open bench/bridge_patterns.txt");
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        code = $fgets(line, fd);
        code = $sscanf(line, "%s %h %h %h %h", kind, f_addr, f_data, f_exp, f_err);
        // Comment and blank lines do not give five fields
        if (code == 5) begin
          run_op();
          ops++;
          repeat ($urandom % 8 + 1) tick();
        end
      end
      $fclose(fd);
    end
    repeat (8) tick();
    $display("done: %0d operations, %0d reads checked, %0d value errors, %0d bench errors",
             ops, reads_done, value_errs, tb_errs);
    if (value_errs == 0 && tb_errs == 0 && reads_done > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- bench/bridge_checker.sv
// Sees only DUT pins and expects APB inputs held steady and SPI frames of at most six bytes
`timescale 1ns/1ns
module bridge_checker (
  input  logic                               clk,
  input  logic                               resetn,
  input  logic                               sck,
  input  logic                               cs,
  input  logic                               copi,
  input  logic                               cipo,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [reg_map_pkg::apb_addr_w-1:0] paddr,
  input  logic [reg_map_pkg::data_w-1:0]     pwdata,
  input  logic [reg_map_pkg::data_w-1:0]     prdata,
  input  logic                               pready,
  input  logic                               pslverr,
  input  logic [reg_map_pkg::data_w-1:0]     exp_data,
  input  logic                               exp_err,
  input  logic [1:0]                         exp_wait,
  output int                                 value_errs,
  output int                                 reads_done
);

  import reg_map_pkg::*;

  // Reference copy of the register contents
  logic [data_w-1:0] model [num_regs];

  logic              sck_d;
  logic              cs_d;
  int                bit_cnt;
  int                byte_cnt;
  int                waits;
  logic [7:0]        in_sh;
  logic [7:0]        out_sh;
  logic [7:0]        opcode;
  logic [7:0]        addr;
  logic [data_w-1:0] word_in;
  logic [data_w-1:0] word_out;
  logic              is_read;
  logic              bad;
  logic [data_w-1:0] want;

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      value_errs++;
      $display("error t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  always @(posedge clk) begin
    if (resetn) begin
      for (int i = 0; i < num_regs; i++) begin
        model[i] = '0;
      end
      sck_d      = 1'b0;
      cs_d       = 1'b1;
      bit_cnt    = 0;
      byte_cnt   = 0;
      waits      = 0;
      value_errs = 0;
      reads_done = 0;
    end else begin
      // New frame on the CS falling edge
      if (!cs && cs_d) begin
        bit_cnt  = 0;
        byte_cnt = 0;
      end
      // Mode 0 samples both lines on the SCK rising edge with the MSB first
      if (!cs && sck && !sck_d) begin
        in_sh   = {in_sh[6:0], copi};
        out_sh  = {out_sh[6:0], cipo};
        bit_cnt = bit_cnt + 1;
        if (bit_cnt == 8 && byte_cnt < 6) begin
          bit_cnt = 0;
          if (byte_cnt == 0) begin
            opcode = in_sh;
          end else if (byte_cnt == 1) begin
            addr = in_sh;
          end else begin
            // Data bytes arrive LSB first
            word_in[8*(byte_cnt-2) +: 8]  = in_sh;
            word_out[8*(byte_cnt-2) +: 8] = out_sh;
          end
          is_read = (opcode == 8'h03) && (addr < 8'd8);
          // CIPO carries data only in the data bytes of a valid read
          if (!(is_read && byte_cnt >= 2)) begin
            compare("cipo", 32'(out_sh), 32'h0);
          end
          if (byte_cnt == 5) begin
            if (opcode == 8'h02 && addr < 8'd8) begin
              model[addr[2:0]] = word_in;
            end
            if (is_read) begin
              compare("cipo word", word_out, model[addr[2:0]]);
              compare("cipo word vs pattern", word_out, exp_data);
              reads_done++;
            end
          end
          byte_cnt = byte_cnt + 1;
        end
      end
      // Wait states counted from the first access cycle
      if (psel && !penable) begin
        waits = 0;
      end
      if (psel && penable && !pready) begin
        waits = waits + 1;
      end
      // APB transfer ends on the access cycle with pready high
      if (psel && penable && pready) begin
        compare("pready wait cycles", 32'(waits), 32'(exp_wait));
        bad = (paddr >= 8'h20) || (paddr[1:0] != 2'b00);
        compare("pslverr", 32'(pslverr), 32'(bad));
        compare("pslverr vs pattern", 32'(pslverr), 32'(exp_err));
        if (pwrite && !bad) begin
          model[paddr[4:2]] = pwdata;
        end
        if (!pwrite) begin
          want = bad ? '0 : model[paddr[4:2]];
          compare("prdata", prdata, want);
          compare("prdata vs pattern", prdata, exp_data);
          reads_done++;
        end
      end
      sck_d = sck;
      cs_d  = cs;
    end
  end

endmodule

//--- verilog/spi_reg_bridge.sv
// SPI mode 0 with CIPO always driven plus an APB host port and a resetn that is active high
`timescale 1ns/1ns
module spi_reg_bridge (
  input  logic                               clk,
  input  logic                               resetn,
  input  logic                               sck,
  input  logic                               cs,
  input  logic                               copi,
  output logic                               cipo,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [reg_map_pkg::apb_addr_w-1:0] paddr,
  input  logic [reg_map_pkg::data_w-1:0]     pwdata,
  output logic [reg_map_pkg::data_w-1:0]     prdata,
  output logic                               pready,
  output logic                               pslverr
);

  import reg_map_pkg::*;

  // Shifter and frame control
  logic [7:0]        rx_byte;
  logic              rx_valid;
  logic              frame_start;
  logic              frame_abort;
  logic [7:0]        tx_byte;
  logic              tx_load;

  // Word assembly
  logic              byte_take;
  logic              byte_give;
  logic              word_clear;
  logic              rd_load;
  logic [data_w-1:0] word_rx;
  logic [7:0]        rd_byte;

  // Bank ports
  logic              spi_re;
  logic              spi_we;
  logic [addr_w-1:0] spi_addr;
  logic [data_w-1:0] spi_rdata;
  logic              bank_we;
  logic [addr_w-1:0] bank_addr;
  logic [data_w-1:0] bank_wdata;
  logic [data_w-1:0] bank_rdata;
  logic              bank_busy;

  spi_byte_shifter i_byte_shifter (
    .clk(clk), .resetn(resetn), .sck(sck), .cs(cs), .copi(copi), .cipo(cipo),
    .tx_byte(tx_byte), .tx_load(tx_load), .rx_byte(rx_byte), .rx_valid(rx_valid),
    .frame_start(frame_start), .frame_abort(frame_abort)
  );

  word_assembler i_word_assembler (
    .clk(clk), .resetn(resetn), .rx_byte(rx_byte), .byte_take(byte_take),
    .byte_give(byte_give), .word_clear(word_clear), .rd_load(rd_load),
    .rd_word(spi_rdata), .word_rx(word_rx), .rd_byte(rd_byte)
  );

  spi_frame_control i_frame_control (
    .clk(clk), .resetn(resetn), .rx_byte(rx_byte), .rx_valid(rx_valid),
    .frame_start(frame_start), .frame_abort(frame_abort), .spi_rdata(spi_rdata),
    .rd_byte(rd_byte), .tx_byte(tx_byte), .tx_load(tx_load), .byte_take(byte_take),
    .byte_give(byte_give), .word_clear(word_clear), .rd_load(rd_load),
    .spi_re(spi_re), .spi_we(spi_we), .spi_addr(spi_addr)
  );

  reg_bank i_reg_bank (
    .clk(clk), .resetn(resetn), .spi_we(spi_we), .spi_re(spi_re), .spi_addr(spi_addr),
    .word_rx(word_rx), .bank_we(bank_we), .bank_addr(bank_addr),
    .bank_wdata(bank_wdata), .spi_rdata(spi_rdata), .bank_rdata(bank_rdata),
    .bank_busy(bank_busy)
  );

  apb_reg_port i_apb_port (
    .clk(clk), .resetn(resetn), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .bank_rdata(bank_rdata), .bank_busy(bank_busy),
    .prdata(prdata), .pready(pready), .pslverr(pslverr), .bank_we(bank_we),
    .bank_addr(bank_addr), .bank_wdata(bank_wdata)
  );

endmodule

//--- verilog/apb_reg_port.sv
// APB completer without pstrb or pprot and with at most one wait state per transfer
`timescale 1ns/1ns
module apb_reg_port (
  input  logic                               clk,
  input  logic                               resetn,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [reg_map_pkg::apb_addr_w-1:0] paddr,
  input  logic [reg_map_pkg::data_w-1:0]     pwdata,
  input  logic [reg_map_pkg::data_w-1:0]     bank_rdata,
  input  logic                               bank_busy,
  output logic [reg_map_pkg::data_w-1:0]     prdata,
  output logic                               pready,
  output logic                               pslverr,
  output logic                               bank_we,
  output logic [reg_map_pkg::addr_w-1:0]     bank_addr,
  output logic [reg_map_pkg::data_w-1:0]     bank_wdata
);

  import reg_map_pkg::*;

  logic access;
  logic addr_ok;
  logic waited;

  assign access  = psel & penable;
  assign addr_ok = (paddr < apb_addr_limit) && (paddr[apb_byte_bits-1:0] == '0);

  // Zero wait states unless SPI is writing in the first access cycle
  assign pready  = access & (~bank_busy | waited);
  assign pslverr = pready & ~addr_ok;

  // Bad addresses never reach the bank
  assign bank_addr  = paddr[apb_byte_bits +: addr_w];
  assign bank_we    = pready & pwrite & addr_ok;
  assign bank_wdata = pwdata;
  assign prdata     = addr_ok ? bank_rdata : '0;

  // Remembers the stretched cycle so the wait never exceeds one cycle
  always_ff @(posedge clk) begin
    if (resetn) begin
      waited <= 1'b0;
    end else begin
      waited <= access & ~pready;
    end
  end

endmodule

//--- verilog/reg_bank.sv
// Eight 32-bit registers with no byte enables and SPI writes winning over APB writes
`timescale 1ns/1ns
module reg_bank (
  input  logic                           clk,
  input  logic                           resetn,
  input  logic                           spi_we,
  input  logic                           spi_re,
  input  logic [reg_map_pkg::addr_w-1:0] spi_addr,
  input  logic [reg_map_pkg::data_w-1:0] word_rx,
  input  logic                           bank_we,
  input  logic [reg_map_pkg::addr_w-1:0] bank_addr,
  input  logic [reg_map_pkg::data_w-1:0] bank_wdata,
  output logic [reg_map_pkg::data_w-1:0] spi_rdata,
  output logic [reg_map_pkg::data_w-1:0] bank_rdata,
  output logic                           bank_busy
);

  import reg_map_pkg::*;

  logic [data_w-1:0] regs [num_regs];

  // Single write port shared by both sides
  always_ff @(posedge clk) begin
    if (resetn) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (spi_we) begin
      regs[spi_addr] <= word_rx;
    end else if (bank_we) begin
      regs[bank_addr] <= bank_wdata;
    end
  end

  // SPI read port, loaded only on request
  always_ff @(posedge clk) begin
    if (spi_re) begin
      spi_rdata <= regs[spi_addr];
    end
  end

  // APB read port runs every cycle
  // A same cycle SPI write is forwarded so a stretched read sees it
  always_ff @(posedge clk) begin
    if (spi_we && spi_addr == bank_addr) begin
      bank_rdata <= word_rx;
    end else begin
      bank_rdata <= regs[bank_addr];
    end
  end

  // APB must hold off while SPI owns the write port
  assign bank_busy = spi_we;

endmodule

//--- verilog/spi_frame_control.sv
// Accepts opcodes 0x02 and 0x03 with addresses below 8 and drains any other frame with zeros
`timescale 1ns/1ns
module spi_frame_control (
  input  logic                           clk,
  input  logic                           resetn,
  input  logic [7:0]                     rx_byte,
  input  logic                           rx_valid,
  input  logic                           frame_start,
  input  logic                           frame_abort,
  input  logic [reg_map_pkg::data_w-1:0] spi_rdata,
  input  logic [7:0]                     rd_byte,
  output logic [7:0]                     tx_byte,
  output logic                           tx_load,
  output logic                           byte_take,
  output logic                           byte_give,
  output logic                           word_clear,
  output logic                           rd_load,
  output logic                           spi_re,
  output logic                           spi_we,
  output logic [reg_map_pkg::addr_w-1:0] spi_addr
);

  import spi_frame_pkg::*;
  import reg_map_pkg::*;

  frame_state_e          state;
  spi_opcode_e           opcode;
  logic [data_cnt_w-1:0] data_cnt;
  logic                  last_data;

  assign last_data = (data_cnt == data_cnt_w'(data_bytes - 1));

  // First read byte is taken straight off the bank port
  // Later ones come from the assembler and everything else sends zeros
  assign tx_byte = rd_load ? spi_rdata[7:0] :
                   (state == st_data && opcode == op_read) ? rd_byte : 8'h00;

  always_ff @(posedge clk) begin
    if (resetn) begin
      state      <= st_idle;
      opcode     <= op_write;
      data_cnt   <= '0;
      spi_addr   <= '0;
      tx_load    <= 1'b0;
      byte_take  <= 1'b0;
      byte_give  <= 1'b0;
      word_clear <= 1'b0;
      rd_load    <= 1'b0;
      spi_re     <= 1'b0;
      spi_we     <= 1'b0;
    end else begin
      byte_take  <= 1'b0;
      byte_give  <= 1'b0;
      word_clear <= 1'b0;
      spi_re     <= 1'b0;
      spi_we     <= 1'b0;
      // Read pipeline goes from bank read to capture and then byte into the shifter
      rd_load    <= spi_re;
      tx_load    <= spi_re | byte_give;
      if (frame_abort) begin
        // CS went high so anything unfinished is dropped
        state <= st_idle;
      end else begin
        case (state)
          st_idle: begin
            if (frame_start) begin
              state      <= st_opcode;
              word_clear <= 1'b1;
              data_cnt   <= '0;
            end
          end
          st_opcode: begin
            if (rx_valid) begin
              if (rx_byte == op_read || rx_byte == op_write) begin
                opcode <= spi_opcode_e'(rx_byte);
                state  <= st_addr;
              end else begin
                state <= st_drain;
              end
            end
          end
          st_addr: begin
            if (rx_valid) begin
              if (rx_byte >= 8'(num_regs)) begin
                state <= st_drain;
              end else begin
                spi_addr <= rx_byte[addr_w-1:0];
                spi_re   <= (opcode == op_read);
                state    <= st_data;
              end
            end
          end
          st_data: begin
            if (rx_valid) begin
              data_cnt <= data_cnt + 1'b1;
              if (opcode == op_write) begin
                byte_take <= 1'b1;
                if (last_data) begin
                  state <= st_commit;
                end
              end else if (last_data) begin
                // Trailing bytes of a read go out as zeros
                state   <= st_drain;
                tx_load <= 1'b1;
              end else begin
                byte_give <= 1'b1;
              end
            end
          end
          st_commit: begin
            spi_we <= 1'b1;
            state  <= st_drain;
          end
          st_drain: begin
            tx_load <= rx_valid;
          end
          default: begin
            state <= st_idle;
          end
        endcase
      end
    end
  end

endmodule

//--- verilog/word_assembler.sv
// Holds one received word and one read word, so a frame moves exactly one 32-bit value
`timescale 1ns/1ns
module word_assembler (
  input  logic                           clk,
  input  logic                           resetn,
  input  logic [7:0]                     rx_byte,
  input  logic                           byte_take,
  input  logic                           byte_give,
  input  logic                           word_clear,
  input  logic                           rd_load,
  input  logic [reg_map_pkg::data_w-1:0] rd_word,
  output logic [reg_map_pkg::data_w-1:0] word_rx,
  output logic [7:0]                     rd_byte
);

  import reg_map_pkg::*;
  import spi_frame_pkg::*;

  logic [data_w-1:0]     rd_hold;
  logic [data_cnt_w-1:0] rd_idx;

  // Receive word
  // New bytes enter at the top so the first byte ends up lowest
  always_ff @(posedge clk) begin
    if (word_clear) begin
      word_rx <= '0;
    end else if (byte_take) begin
      word_rx <= {rx_byte, word_rx[data_w-1:8]};
    end
  end

  // Snapshot of the bank read port
  always_ff @(posedge clk) begin
    if (rd_load) begin
      rd_hold <= rd_word;
    end
  end

  // Byte select walks upward from the low byte
  always_ff @(posedge clk) begin
    if (resetn) begin
      rd_idx <= '0;
    end else if (word_clear || rd_load) begin
      rd_idx <= '0;
    end else if (byte_give) begin
      rd_idx <= rd_idx + 1'b1;
    end
  end

  assign rd_byte = rd_hold[{rd_idx, 3'b000} +: 8];

endmodule

//--- verilog/spi_byte_shifter.sv
// SPI mode 0 only and SCK must stay well below clk/4 since all pins are sampled with clk
`timescale 1ns/1ns
module spi_byte_shifter (
  input  logic       clk,
  input  logic       resetn,
  input  logic       sck,
  input  logic       cs,
  input  logic       copi,
  input  logic [7:0] tx_byte,
  input  logic       tx_load,
  output logic       cipo,
  output logic [7:0] rx_byte,
  output logic       rx_valid,
  output logic       frame_start,
  output logic       frame_abort
);

  // Two sync stages plus one history bit for edge detection
  logic [2:0] sck_s;
  logic [2:0] cs_s;
  logic [1:0] copi_s;

  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;

  logic [6:0] rx_shift;
  logic [2:0] rx_cnt;
  logic [7:0] tx_shift;
  logic [7:0] tx_next;
  logic [2:0] tx_cnt;

  always_ff @(posedge clk) begin
    if (resetn) begin
      sck_s  <= '0;
      // CS idles high so no false frame start after reset
      cs_s   <= '1;
      copi_s <= '0;
    end else begin
      sck_s  <= {sck_s[1:0], sck};
      cs_s   <= {cs_s[1:0], cs};
      copi_s <= {copi_s[0], copi};
    end
  end

  assign sck_rise  = sck_s[1] & ~sck_s[2];
  assign sck_fall  = ~sck_s[1] & sck_s[2];
  assign cs_active = ~cs_s[1];

  // Single cycle pulses on CS edges
  assign frame_start = ~cs_s[1] & cs_s[2];
  assign frame_abort = cs_s[1] & ~cs_s[2];

  // Bit counter and byte strobe
  always_ff @(posedge clk) begin
    if (resetn) begin
      rx_cnt   <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!cs_active) begin
        rx_cnt <= '0;
      end else if (sck_rise) begin
        rx_cnt   <= rx_cnt + 3'd1;
        rx_valid <= (rx_cnt == 3'd7);
      end
    end
  end

  // Receive data path with the MSB arriving first
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      rx_shift <= {rx_shift[5:0], copi_s[1]};
      // Whole byte held until the next one completes
      if (rx_cnt == 3'd7) begin
        rx_byte <= {rx_shift, copi_s[1]};
      end
    end
  end

  // Transmit side
  // The 8th falling edge of a byte moves tx_next into the output register
  always_ff @(posedge clk) begin
    if (resetn || !cs_active) begin
      tx_cnt   <= '0;
      tx_shift <= '0;
      tx_next  <= '0;
    end else begin
      if (tx_load) begin
        tx_next <= tx_byte;
      end
      if (sck_fall) begin
        tx_cnt <= tx_cnt + 3'd1;
        if (tx_cnt == 3'd7) begin
          tx_shift <= tx_next;
        end else begin
          tx_shift <= {tx_shift[6:0], 1'b0};
        end
      end
    end
  end

  // Driven low whenever deselected
  assign cipo = cs_active & tx_shift[7];

endmodule

//--- verilog/reg_map_pkg.sv
// Fixed map of eight 32-bit registers at word aligned APB byte addresses 0x00 to 0x1c
package reg_map_pkg;

  // Register bank shape
  localparam int num_regs = 8;
  localparam int addr_w   = 3;
  localparam int data_w   = 32;

  // Host bus address width
  localparam int apb_addr_w = 8;

  // Byte offset bits below the register index
  localparam int apb_byte_bits = 2;

  // Accesses at or above this byte address get pslverr
  localparam int apb_addr_limit = num_regs << apb_byte_bits;

  // Misaligned accesses also get pslverr
  // The check looks only at the byte offset bits

endpackage

//--- verilog/spi_frame_pkg.sv
// Frames are mode 0 only and always carry exactly four data bytes after opcode and address
package spi_frame_pkg;

  // Opcode in byte 0 of a frame
  // Any other value makes the whole frame ignored
  typedef enum logic [7:0] {
    op_write = 8'h02,
    op_read  = 8'h03
  } spi_opcode_e;

  // Frame control FSM
  typedef enum logic [2:0] {
    st_idle,
    st_opcode,
    st_addr,
    st_data,
    st_commit,
    st_drain
  } frame_state_e;

  // Data bytes after opcode and address travel LSB first
  localparam int data_bytes = 4;
  // Counter width over the data bytes
  localparam int data_cnt_w = $clog2(data_bytes);

endpackage
